// ==== include/rover_drive_consts.svh ====
`ifndef ROVER_DRIVE_CONSTS_SVH
`define ROVER_DRIVE_CONSTS_SVH

// base cycles per 15 degree step, sized for simulation
`define ANGLE_UNIT_CYCLES 40
// base cycles per 4 inch step, sized for simulation
`define DIST_UNIT_CYCLES 40
// extra cycles added to a unit per trim count
`define TRIM_STEP_CYCLES 4
// settling pause between turn and drive
`define PAUSE_CYCLES 20

// command queue size
`define QUEUE_DEPTH 4
// fill count width, holds 0 to QUEUE_DEPTH
`define QUEUE_COUNT_W 3

// apb register offsets
`define REG_CMD 8'h00
`define REG_TRIM 8'h04
`define REG_STATUS 8'h08

`endif

// ==== hw/rover_drive_pkg.sv ====
package rover_drive_pkg;

   ////////////////////////////////
   // move command
   ////////////////////////////////

   // one queued move for the rover
   // angle sits in the upper bits so the host word reads as {angle, distance}
   typedef struct packed {
      // number of 15 degree pivot steps
      logic [4:0] angle;
      // number of 4 inch forward steps
      logic [6:0] distance;
   } move_cmd_t;

   ////////////////////////////////
   // sequencer phases
   ////////////////////////////////

   // a move walks idle -> turning -> pause -> moving -> idle
   // angle zero enters moving straight from idle
   // distance zero never leaves idle
   typedef enum logic [1:0] {
      // waiting for the next command
      idle    = 2'd0,
      // pivot turn on the right wheel only
      turning = 2'd1,
      // all motors off to let the drive settle
      pause   = 2'd2,
      // both wheels forward
      moving  = 2'd3
   } drive_phase_t;

endpackage

// ==== hw/apb_drive_regs.sv ====
`timescale 1ns/1ns
`include "rover_drive_consts.svh"

module apb_drive_regs (
   input  logic                         clock,
   input  logic                         rst_n,
   input  logic [7:0]                   paddr,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [31:0]                  pwdata,
   input  logic                         full,
   input  logic [`QUEUE_COUNT_W-1:0]    count,
   input  logic                         busy,
   input  logic                         move_done,
   output logic [31:0]                  prdata,
   output logic                         pready,
   output logic                         pslverr,
   output logic                         push,
   output rover_drive_pkg::move_cmd_t   push_cmd,
   output logic [3:0]                   angle_trim,
   output logic [3:0]                   dist_trim
);

   ////////////////////////////////
   // access decode
   ////////////////////////////////

   logic        access;
   logic        sel_cmd;
   logic        sel_trim;
   logic        sel_status;
   logic        unmapped;
   logic [7:0]  trim_q;
   logic [7:0]  done_count;
   logic [31:0] status_word;

   // zero wait states so every access ends in its access phase
   assign pready = 1'b1;
   assign access = psel && penable;

   assign sel_cmd    = (paddr == `REG_CMD);
   assign sel_trim   = (paddr == `REG_TRIM);
   assign sel_status = (paddr == `REG_STATUS);
   assign unmapped   = !(sel_cmd || sel_trim || sel_status);

   // error on a hole in the map or on a command the queue cannot take
   assign pslverr = access && (unmapped || (sel_cmd && pwrite && full));

   ////////////////////////////////
   // command push
   ////////////////////////////////

   // low 12 bits of the write data form the command
   assign push_cmd = rover_drive_pkg::move_cmd_t'(pwdata[11:0]);
   // a refused write never reaches the queue
   assign push = access && pwrite && sel_cmd && !full;

   ////////////////////////////////
   // trim register
   ////////////////////////////////

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         trim_q <= 8'h00;
      end else if (access && pwrite && sel_trim) begin
         trim_q <= pwdata[7:0];
      end
   end

   // sequencer samples these only when a move starts
   assign angle_trim = trim_q[3:0];
   assign dist_trim  = trim_q[7:4];

   ////////////////////////////////
   // completion counter
   ////////////////////////////////

   // one count per finished move, wraps at 256
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         done_count <= 8'h00;
      end else if (move_done) begin
         done_count <= done_count + 8'h01;
      end
   end

   ////////////////////////////////
   // read data
   ////////////////////////////////

   // busy in bit 0, fill count above it, completions in the second byte
   assign status_word = {16'h0000, done_count, 4'h0, count, busy};

   always_comb begin
      prdata = 32'h0000_0000;
      // cmd and unmapped offsets read back zero
      if (psel && !pwrite) begin
         if (sel_trim) begin
            prdata = {24'h00_0000, trim_q};
         end else if (sel_status) begin
            prdata = status_word;
         end
      end
   end

endmodule

// ==== hw/move_queue.sv ====
`timescale 1ns/1ns
`include "rover_drive_consts.svh"

module move_queue (
   input  logic                         clock,
   input  logic                         rst_n,
   input  logic                         push,
   input  rover_drive_pkg::move_cmd_t   push_cmd,
   input  logic                         cmd_ready,
   output logic                         full,
   output logic [`QUEUE_COUNT_W-1:0]    count,
   output logic                         cmd_valid,
   output rover_drive_pkg::move_cmd_t   cmd
);

   localparam int PTR_W = $clog2(`QUEUE_DEPTH);

   // storage has no reset, only the pointers and count do
   rover_drive_pkg::move_cmd_t mem [`QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign full      = (count == `QUEUE_COUNT_W'(`QUEUE_DEPTH));
   assign cmd_valid = (count != '0);
   // head entry is always visible to the sequencer
   assign cmd       = mem[rd_ptr];

   // handshake on the consumer side
   assign do_pop  = cmd_valid && cmd_ready;
   // guard against an overfill
   assign do_push = push && !full;

   always_ff @(posedge clock) begin
      if (do_push) begin
         mem[wr_ptr] <= push_cmd;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap at the last entry
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         end
         // push and pop together leave the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + `QUEUE_COUNT_W'(1);
            2'b01:   count <= count - `QUEUE_COUNT_W'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== hw/motor_sequencer.sv ====
`timescale 1ns/1ns
`include "rover_drive_consts.svh"

module motor_sequencer (
   input  logic                         clock,
   input  logic                         rst_n,
   input  logic                         cmd_valid,
   input  rover_drive_pkg::move_cmd_t   cmd,
   input  logic [3:0]                   angle_trim,
   input  logic [3:0]                   dist_trim,
   output logic                         cmd_ready,
   output logic                         busy,
   output logic                         move_done,
   output logic                         motor_l_f,
   output logic                         motor_r_f,
   output logic                         motor_l_b,
   output logic                         motor_r_b
);

   ////////////////////////////////
   // counter sizing
   ////////////////////////////////

   // longest unit is the base plus a full trim of 15
   localparam int ANGLE_MAX = `ANGLE_UNIT_CYCLES + 15 * `TRIM_STEP_CYCLES;
   localparam int DIST_MAX  = `DIST_UNIT_CYCLES + 15 * `TRIM_STEP_CYCLES;
   localparam int SUB_MAX   = (ANGLE_MAX > DIST_MAX) ? ANGLE_MAX : DIST_MAX;
   localparam int SUB_W     = $clog2(SUB_MAX + 1);
   localparam int PAUSE_W   = $clog2(`PAUSE_CYCLES + 1);

   rover_drive_pkg::drive_phase_t phase;

   // command and unit lengths captured at accept
   logic [4:0]         angle_q;
   logic [6:0]         dist_q;
   logic [SUB_W-1:0]   angle_goal;
   logic [SUB_W-1:0]   dist_goal;

   // one step and sub-step pair serves both turn and drive
   logic [6:0]         step_count;
   logic [SUB_W-1:0]   sub_count;
   logic [PAUSE_W-1:0] pause_count;

   logic [6:0]         step_goal;
   logic [SUB_W-1:0]   sub_goal;
   logic               sub_last;
   logic               step_last;
   logic               accept;

   ////////////////////////////////
   // handshake and status
   ////////////////////////////////

   // only an idle sequencer takes the head entry
   assign accept    = cmd_valid && (phase == rover_drive_pkg::idle);
   assign cmd_ready = accept;
   assign busy      = (phase != rover_drive_pkg::idle);

   // reverse drive is not supported
   assign motor_l_b = 1'b0;
   assign motor_r_b = 1'b0;

   // goals for the phase in progress
   assign step_goal = (phase == rover_drive_pkg::turning) ? {2'b00, angle_q} : dist_q;
   assign sub_goal  = (phase == rover_drive_pkg::turning) ? angle_goal : dist_goal;
   assign sub_last  = (sub_count == sub_goal - SUB_W'(1));
   assign step_last = (step_count == step_goal - 7'd1);

   // latch the command and the trimmed unit lengths
   // later trim writes do not touch a move in progress
   always_ff @(posedge clock) begin
      if (accept) begin
         angle_q    <= cmd.angle;
         dist_q     <= cmd.distance;
         angle_goal <= SUB_W'(`ANGLE_UNIT_CYCLES)
                       + SUB_W'(angle_trim) * SUB_W'(`TRIM_STEP_CYCLES);
         dist_goal  <= SUB_W'(`DIST_UNIT_CYCLES)
                       + SUB_W'(dist_trim) * SUB_W'(`TRIM_STEP_CYCLES);
      end
   end

   ////////////////////////////////
   // phase FSM
   ////////////////////////////////

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         phase       <= rover_drive_pkg::idle;
         motor_l_f   <= 1'b0;
         motor_r_f   <= 1'b0;
         move_done   <= 1'b0;
         step_count  <= '0;
         sub_count   <= '0;
         pause_count <= '0;
      end else begin
         // done is a single cycle pulse
         move_done <= 1'b0;
         case (phase)
            rover_drive_pkg::idle: begin
               if (accept) begin
                  step_count  <= '0;
                  sub_count   <= '0;
                  pause_count <= '0;
                  if (cmd.distance == 7'd0) begin
                     // nothing to drive, finish at once
                     move_done <= 1'b1;
                  end else if (cmd.angle == 5'd0) begin
                     // straight ahead, no turn and no pause
                     phase     <= rover_drive_pkg::moving;
                     motor_l_f <= 1'b1;
                     motor_r_f <= 1'b1;
                  end else begin
                     // pivot on the right wheel
                     phase     <= rover_drive_pkg::turning;
                     motor_r_f <= 1'b1;
                  end
               end
            end

            rover_drive_pkg::turning,
            rover_drive_pkg::moving: begin
               if (sub_last) begin
                  sub_count <= '0;
                  if (step_last) begin
                     step_count <= '0;
                     motor_l_f  <= 1'b0;
                     motor_r_f  <= 1'b0;
                     if (phase == rover_drive_pkg::turning) begin
                        phase <= rover_drive_pkg::pause;
                     end else begin
                        // motors off and done in the same cycle
                        phase     <= rover_drive_pkg::idle;
                        move_done <= 1'b1;
                     end
                  end else begin
                     step_count <= step_count + 7'd1;
                  end
               end else begin
                  sub_count <= sub_count + SUB_W'(1);
               end
            end

            rover_drive_pkg::pause: begin
               // all off for the settling time then both forward
               if (pause_count == PAUSE_W'(`PAUSE_CYCLES - 1)) begin
                  pause_count <= '0;
                  phase       <= rover_drive_pkg::moving;
                  motor_l_f   <= 1'b1;
                  motor_r_f   <= 1'b1;
               end else begin
                  pause_count <= pause_count + PAUSE_W'(1);
               end
            end

            default: begin
               phase <= rover_drive_pkg::idle;
            end
         endcase
      end
   end

endmodule

// ==== hw/rover_drive_top.sv ====
`timescale 1ns/1ns
`include "rover_drive_consts.svh"

module rover_drive_top (
   input  logic        clock,
   input  logic        rst_n,
   input  logic [7:0]  paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        motor_l_f,
   output logic        motor_r_f,
   output logic        motor_l_b,
   output logic        motor_r_b
);

   // register block to queue
   logic                         push;
   rover_drive_pkg::move_cmd_t   push_cmd;
   logic                         full;
   logic [`QUEUE_COUNT_W-1:0]    count;

   // queue to sequencer
   logic                         cmd_valid;
   logic                         cmd_ready;
   rover_drive_pkg::move_cmd_t   cmd;

   // sequencer and register block
   logic                         busy;
   logic                         move_done;
   logic [3:0]                   angle_trim;
   logic [3:0]                   dist_trim;

   ////////////////////////////////
   // host side
   ////////////////////////////////

   apb_drive_regs u_regs (
      .clock      (clock),
      .rst_n      (rst_n),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .full       (full),
      .count      (count),
      .busy       (busy),
      .move_done  (move_done),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .push       (push),
      .push_cmd   (push_cmd),
      .angle_trim (angle_trim),
      .dist_trim  (dist_trim)
   );

   move_queue u_queue (
      .clock     (clock),
      .rst_n     (rst_n),
      .push      (push),
      .push_cmd  (push_cmd),
      .cmd_ready (cmd_ready),
      .full      (full),
      .count     (count),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   ////////////////////////////////
   // motor side
   ////////////////////////////////

   motor_sequencer u_seq (
      .clock      (clock),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .angle_trim (angle_trim),
      .dist_trim  (dist_trim),
      .cmd_ready  (cmd_ready),
      .busy       (busy),
      .move_done  (move_done),
      .motor_l_f  (motor_l_f),
      .motor_r_f  (motor_r_f),
      .motor_l_b  (motor_l_b),
      .motor_r_b  (motor_r_b)
   );

endmodule

// ==== sim/rover_drive_asserts.sv ====
`timescale 1ns/1ns

module rover_drive_asserts (
   input logic                          clock,
   input logic                          rst_n,
   input rover_drive_pkg::drive_phase_t phase,
   input logic                          cmd_ready,
   input logic                          busy,
   input logic                          move_done,
   input logic                          motor_l_f,
   input logic                          motor_r_f,
   input logic                          motor_l_b,
   input logic                          motor_r_b
);

   //////////////////////////////
   // motor outputs
   //////////////////////////////

   no_reverse: assert property (@(posedge clock) disable iff (!rst_n)
      !motor_l_b && !motor_r_b)
      else $error("backward motor output driven");

   // both directions on one side would short the bridge
   no_shoot_through: assert property (@(posedge clock) disable iff (!rst_n)
      !(motor_l_f && motor_l_b) && !(motor_r_f && motor_r_b))
      else $error("forward and backward high on the same side");

   turn_pattern: assert property (@(posedge clock) disable iff (!rst_n)
      (phase == rover_drive_pkg::turning) |-> (motor_r_f && !motor_l_f))
      else $error("turn phase without right wheel only");

   // idle and pause keep every motor off
   quiet_pattern: assert property (@(posedge clock) disable iff (!rst_n)
      (phase == rover_drive_pkg::idle || phase == rover_drive_pkg::pause)
      |-> (!motor_l_f && !motor_r_f))
      else $error("motor driven while idle or pausing");

   //////////////////////////////
   // handshakes
   //////////////////////////////

   // a second pulse only follows an accept in the pulse cycle
   done_single: assert property (@(posedge clock) disable iff (!rst_n)
      move_done |=> (!move_done || $past(cmd_ready)))
      else $error("move_done held longer than one cycle");

   done_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
      move_done |-> (phase == rover_drive_pkg::idle))
      else $error("move_done outside idle");

   // a taken command either starts a move or finishes at once
   accept_starts_move: assert property (@(posedge clock) disable iff (!rst_n)
      cmd_ready |=> (busy || move_done))
      else $error("accepted command started no move");

   // busy only begins through a handshake on the queue head
   busy_after_accept: assert property (@(posedge clock) disable iff (!rst_n)
      $rose(busy) |-> $past(cmd_ready))
      else $error("busy raised without an accepted command");

endmodule

bind motor_sequencer rover_drive_asserts u_asserts (
   .clock     (clock),
   .rst_n     (rst_n),
   .phase     (phase),
   .cmd_ready (cmd_ready),
   .busy      (busy),
   .move_done (move_done),
   .motor_l_f (motor_l_f),
   .motor_r_f (motor_r_f),
   .motor_l_b (motor_l_b),
   .motor_r_b (motor_r_b)
);

// ==== sim/rover_drive_tb.sv ====
`timescale 1ns/1ns
`include "rover_drive_consts.svh"

module rover_drive_tb;

   localparam int TIMEOUT_CYCLES = 20000;
   localparam logic [31:0] LFSR_SEED = 32'h749e_7b23;
   localparam int NUM_ROWS = 6;

   logic        clock;
   logic        rst_n;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        motor_l_f;
   logic        motor_r_f;
   logic        motor_l_b;
   logic        motor_r_b;

   // one directed move with its expected turn and drive lengths
   typedef struct packed {
      logic [4:0]  angle;
      logic [6:0]  distance;
      logic [7:0]  trim;
      logic [15:0] turn;
      logic [15:0] drive;
   } move_row_t;

   // trim is {dist_trim, angle_trim}
   move_row_t move_rows [NUM_ROWS] = '{
      '{5'd2, 7'd3, 8'h00, 16'd80,  16'd120},
      '{5'd1, 7'd2, 8'h21, 16'd44,  16'd96},
      '{5'd3, 7'd1, 8'h5a, 16'd240, 16'd60},
      '{5'd0, 7'd2, 8'h13, 16'd0,   16'd88},
      '{5'd4, 7'd0, 8'h00, 16'd0,   16'd0},
      '{5'd1, 7'd1, 8'hf0, 16'd40,  16'd100}
   };

   // {angle, distance} words for the queue fill, the last one is refused
   logic [11:0] burst [6] = '{
      {5'd0, 7'd3}, {5'd1, 7'd1}, {5'd0, 7'd2},
      {5'd2, 7'd1}, {5'd1, 7'd2}, {5'd3, 7'd3}
   };

   // monitor state
   int run_pats [$];
   int run_lens [$];
   int gap_lens [$];
   rover_drive_pkg::move_cmd_t accepted [$];
   int prev_pat = 0;
   int older_pat = 0;
   int run_count = 0;
   int done_seen = 0;
   int moves_sent = 0;
   logic [31:0] lfsr_state = LFSR_SEED;

   rover_drive_top DUT (
      .clock     (clock),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .motor_l_f (motor_l_f),
      .motor_r_f (motor_r_f),
      .motor_l_b (motor_l_b),
      .motor_r_b (motor_r_b)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   //////////////////////////////
   // reporting and compares
   //////////////////////////////

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_cmd(input string what, input rover_drive_pkg::move_cmd_t got,
                            input rover_drive_pkg::move_cmd_t exp);
      if (got !== exp) begin
         stop_run($sformatf("Error at %0t ns: %s expected %03h, got %03h",
                            $time, what, exp, got));
      end
   endtask

   task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, got));
      end
   endtask

   task automatic check_cycles(input string what, input int got, input int exp);
      if (got != exp) begin
         stop_run($sformatf("Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, got));
      end
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("Error at %0t ns: %s expected %08h, got %08h",
                            $time, what, exp, got));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("Error at %0t ns: %s expected %0b, got %0b", $time, what, exp, got));
      end
   endtask

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
   endtask

   // phase length from the unit time and trim
   function automatic int rule_cycles(input int steps, input int unit, input int trim);
      return steps * (unit + trim * `TRIM_STEP_CYCLES);
   endfunction

   // setup phase, then access phase sampled mid cycle
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                             output logic [31:0] rdata, output logic err);
      @(posedge clock);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clock);
      penable <= 1'b1;
      @(negedge clock);
      // zero wait states, the access ends in this cycle
      check_flag("pready", pready, 1'b1);
      rdata = prdata;
      err   = pslverr;
      @(posedge clock);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic wait_moves(input int target);
      int cycles;
      cycles = 0;
      while (done_seen < target) begin
         @(posedge clock);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timed out waiting for a move to complete");
         end
      end
   endtask

   task automatic expect_run(input int pat, input int len);
      if (run_lens.size() == 0) begin
         stop_run("a motor run was expected but none was recorded");
      end
      check_cycles("motor pattern {l_f,r_f}", run_pats.pop_front(), pat);
      check_cycles("motor run cycles", run_lens.pop_front(), len);
   endtask

   // compare the taken command and its recorded motor runs
   task automatic check_move(input rover_drive_pkg::move_cmd_t mc, input int turn,
                             input int drive);
      if (accepted.size() == 0) begin
         stop_run("the sequencer took no command");
      end
      check_cmd("accepted cmd", accepted.pop_front(), mc);
      if (mc.distance != 7'd0) begin
         if (mc.angle != 5'd0) begin
            expect_run(1, turn);
            if (gap_lens.size() == 0) begin
               stop_run("no settling pause between turn and drive");
            end
            check_cycles("pause cycles", gap_lens.pop_front(), `PAUSE_CYCLES);
         end
         expect_run(3, drive);
      end
   endtask

   // one move on its own, optional trim write while it runs
   task automatic run_move(input rover_drive_pkg::move_cmd_t mc, input logic [7:0] trim,
                           input int turn, input int drive, input logic late);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, `REG_TRIM, {24'h00_0000, trim}, rdata, err);
      check_flag("pslverr on TRIM write", err, 1'b0);
      apb_access(1'b0, `REG_TRIM, 32'h0, rdata, err);
      check_word("prdata of TRIM", rdata, {24'h00_0000, trim});
      apb_access(1'b1, `REG_CMD, {20'h0_0000, mc}, rdata, err);
      check_flag("pslverr on CMD write", err, 1'b0);
      moves_sent++;
      if (late) begin
         // must not reach the move already accepted
         apb_access(1'b1, `REG_TRIM, {24'h00_0000, ~trim}, rdata, err);
      end
      wait_moves(moves_sent);
      check_move(mc, turn, drive);
      check_cycles("leftover motor runs", run_lens.size(), 0);
      apb_access(1'b0, `REG_STATUS, 32'h0, rdata, err);
      check_count("STATUS completion count", rdata[15:8], 8'(moves_sent));
      check_cycles("STATUS busy and fill", int'(rdata[3:0]), 0);
   endtask

   //////////////////////////////
   // motor monitor
   //////////////////////////////

   always @(negedge clock) begin
      int pat;
      if (rst_n) begin
         pat = int'({motor_l_f, motor_r_f});
         if (motor_l_b || motor_r_b) begin
            stop_run("a backward motor output was driven");
         end
         if (pat == 2) begin
            stop_run("left motor driven without the right one");
         end
         if (pat == prev_pat) begin
            run_count++;
         end else begin
            if (prev_pat != 0) begin
               run_pats.push_back(prev_pat);
               run_lens.push_back(run_count);
            end else if (pat == 3 && older_pat == 1) begin
               // off run between a turn and a drive
               gap_lens.push_back(run_count);
            end
            older_pat = prev_pat;
            prev_pat  = pat;
            run_count = 1;
         end
         if (DUT.cmd_ready) begin
            accepted.push_back(DUT.cmd);
         end
         if (DUT.move_done) begin
            done_seen++;
         end
      end
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      logic [31:0] rdata;
      logic        err;
      rover_drive_pkg::move_cmd_t mc;
      int a;
      int d;
      int t;

      rst_n   = 1'b0;
      paddr   = 8'h00;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = 32'h0;
      repeat (8) @(posedge clock);
      rst_n <= 1'b1;

      // idle state and holes in the map
      apb_access(1'b0, `REG_STATUS, 32'h0, rdata, err);
      check_word("prdata of STATUS after reset", rdata, 32'h0);
      apb_access(1'b0, 8'h0c, 32'h0, rdata, err);
      check_flag("pslverr on unmapped read", err, 1'b1);
      check_word("prdata of unmapped read", rdata, 32'h0);
      apb_access(1'b1, 8'h10, 32'hffff_ffff, rdata, err);
      check_flag("pslverr on unmapped write", err, 1'b1);
      apb_access(1'b0, `REG_CMD, 32'h0, rdata, err);
      check_word("prdata of CMD", rdata, 32'h0);

      // directed table, trim rewritten while each move runs
      for (int i = 0; i < NUM_ROWS; i++) begin
         mc.angle    = move_rows[i].angle;
         mc.distance = move_rows[i].distance;
         run_move(mc, move_rows[i].trim, int'(move_rows[i].turn),
                  int'(move_rows[i].drive), 1'b1);
      end

      // queue fill behind a running move
      apb_access(1'b1, `REG_TRIM, 32'h0, rdata, err);
      for (int i = 0; i < 6; i++) begin
         apb_access(1'b1, `REG_CMD, {20'h0_0000, burst[i]}, rdata, err);
         check_flag("pslverr on queued CMD write", err, (i == 5));
         if (i < 5) begin
            moves_sent++;
         end
      end
      apb_access(1'b0, `REG_STATUS, 32'h0, rdata, err);
      check_cycles("STATUS fill count", int'(rdata[3:1]), `QUEUE_DEPTH);
      check_flag("STATUS busy", rdata[0], 1'b1);
      wait_moves(moves_sent);
      for (int i = 0; i < 5; i++) begin
         mc = rover_drive_pkg::move_cmd_t'(burst[i]);
         check_move(mc, rule_cycles(int'(mc.angle), `ANGLE_UNIT_CYCLES, 0),
                    rule_cycles(int'(mc.distance), `DIST_UNIT_CYCLES, 0));
      end

      // random moves and trims
      for (int n = 0; n < 6; n++) begin
         take_bits(2, a);
         take_bits(2, d);
         take_bits(8, t);
         mc.angle    = 5'(a);
         mc.distance = 7'(d);
         run_move(mc, 8'(t), rule_cycles(a, `ANGLE_UNIT_CYCLES, t & 15),
                  rule_cycles(d, `DIST_UNIT_CYCLES, t >> 4), 1'b0);
      end

      if (run_lens.size() != 0 || gap_lens.size() != 0 || accepted.size() != 0) begin
         stop_run("motor runs or commands were left unchecked at the end");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

// ==== rover_drive_top.f ====
+incdir+include
hw/rover_drive_pkg.sv
hw/apb_drive_regs.sv
hw/move_queue.sv
hw/motor_sequencer.sv
hw/rover_drive_top.sv
sim/rover_drive_asserts.sv
sim/rover_drive_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rover drive testbench with Verilator
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/1ns \
   --top-module rover_drive_tb \
   -f rover_drive_top.f \
   -o rover_drive_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/rover_drive_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
